/* dv/cpu_back_end_checker.sv */
module cpu_back_end_checker (
	input logic                   CLK,
	input logic                   nRST,
	input logic                   stall,
	input logic                   halted,
	input cpu_types_pkg::mem_wb_t wb
);

	// write-back bundle frozen across a stalled or halted edge
	assert property (@(posedge CLK) disable iff (!nRST) (stall || halted) |=> $stable(wb))
		else $error("wb changed while stalled or halted");

	// halted is sticky
	assert property (@(posedge CLK) disable iff (!nRST) halted |=> halted)
		else $error("halted dropped without reset");

	// first edge out of reset sees a bubble on wb
	assert property (@(posedge CLK) $rose(nRST) |-> !wb.wen)
		else $error("wb.wen high right after reset");

endmodule

bind cpu_back_end cpu_back_end_checker checker_i (
	.CLK    (CLK),
	.nRST   (nRST),
	.stall  (stall),
	.halted (halted),
	.wb     (wb)
);

/* dv/cpu_back_end_tb.sv */
module cpu_back_end_tb;

	logic CLK = 1'b0;
	logic nRST;
	cpu_types_pkg::id_ex_t  id_ex;
	logic stall;
	logic flush;
	cpu_types_pkg::mem_wb_t wb;
	logic halted;

	// stimulus table and expected wb after each entry's edge
	cpu_types_pkg::id_ex_t  id_q[$];
	logic                   stall_q[$];
	logic                   flush_q[$];
	string                  name_q[$];
	cpu_types_pkg::mem_wb_t exp_q[$];
	logic                   exp_halted_q[$];

	// reference model state
	cpu_types_pkg::ex_mem_t m_ex = '0;
	cpu_types_pkg::mem_wb_t m_wb = '0;
	logic                   m_halted = 1'b0;
	cpu_types_pkg::word_t   m_mem [cpu_types_pkg::DMEM_WORDS];
	cpu_types_pkg::word_t   pc = '0;
	int errors = 0;
	int checks = 0;
	logic built = 1'b0;

	cpu_back_end cpu_back_end_i (
		.CLK    (CLK),
		.nRST   (nRST),
		.id_ex  (id_ex),
		.stall  (stall),
		.flush  (flush),
		.wb     (wb),
		.halted (halted)
	);

	always #10 CLK = ~CLK;

	function automatic cpu_types_pkg::id_ex_t make_id(cpu_types_pkg::aluop_t op, logic src,
			cpu_types_pkg::word_t a, cpu_types_pkg::word_t b, cpu_types_pkg::word_t imm,
			logic dsel, logic wen, logic dren, logic dwen, logic halt, logic m2r);
		cpu_types_pkg::id_ex_t id;
		id = '0;
		id.imemaddr = pc;
		id.alu_op = op;
		id.alu_src = src;
		id.rdat1 = a;
		id.rdat2 = b;
		id.imm_ext = imm;
		id.rt = cpu_types_pkg::regbits_t'($urandom);
		id.rd = cpu_types_pkg::regbits_t'($urandom);
		id.reg_dest = dsel;
		id.wen = wen;
		id.dren = dren;
		id.dwen = dwen;
		id.halt = halt;
		id.mem_to_reg = m2r;
		pc = pc + 4;
		return id;
	endfunction

	// execute stage as the ALU rules describe it
	function automatic cpu_types_pkg::ex_mem_t run_execute(cpu_types_pkg::id_ex_t id);
		cpu_types_pkg::ex_mem_t e;
		cpu_types_pkg::word_t b;
		b = id.alu_src ? id.imm_ext : id.rdat2;
		e = '0;
		unique case (id.alu_op)
			cpu_types_pkg::ALU_ADD: e.result = id.rdat1 + b;
			cpu_types_pkg::ALU_SUB: e.result = id.rdat1 - b;
			cpu_types_pkg::ALU_AND: e.result = id.rdat1 & b;
			cpu_types_pkg::ALU_OR:  e.result = id.rdat1 | b;
			cpu_types_pkg::ALU_XOR: e.result = id.rdat1 ^ b;
			cpu_types_pkg::ALU_NOR: e.result = ~(id.rdat1 | b);
			cpu_types_pkg::ALU_SLT: e.result = ($signed(id.rdat1) < $signed(b)) ? 32'd1 : 32'd0;
			cpu_types_pkg::ALU_SLL: e.result = id.rdat1 << b[4:0];
			cpu_types_pkg::ALU_SRL: e.result = id.rdat1 >> b[4:0];
			default:                e.result = '0;
		endcase
		e.imemaddr = id.imemaddr;
		e.store_data = id.rdat2;
		e.dest = (id.reg_dest == cpu_types_pkg::SEL_RT) ? id.rt : id.rd;
		e.wen = id.wen;
		e.dren = id.dren;
		e.dwen = id.dwen;
		e.halt = id.halt;
		e.mem_to_reg = id.mem_to_reg;
		return e;
	endfunction

	// steps the model one edge and stores the entry with its expectation
	task automatic add_entry(string name, cpu_types_pkg::id_ex_t id, logic st, logic fl);
		cpu_types_pkg::mem_wb_t nwb;
		logic adv;
		logic nh;
		adv = !m_halted && !st;
		nh = m_halted || m_wb.halt;
		if (adv) begin
			nwb.imemaddr = m_ex.imemaddr;
			nwb.dest = m_ex.dest;
			nwb.wen = m_ex.wen;
			nwb.halt = m_ex.halt;
			nwb.wdat = (m_ex.mem_to_reg == cpu_types_pkg::SEL_DMEM) ?
				m_mem[m_ex.result[7:2]] : m_ex.result;
			if (m_ex.dwen) begin
				m_mem[m_ex.result[7:2]] = m_ex.store_data;
			end
			m_wb = nwb;
		end
		if (fl) begin
			m_ex = '0;
		end else if (adv) begin
			m_ex = run_execute(id);
		end
		m_halted = nh;
		id_q.push_back(id);
		stall_q.push_back(st);
		flush_q.push_back(fl);
		name_q.push_back(name);
		exp_q.push_back(m_wb);
		exp_halted_q.push_back(m_halted);
	endtask

	task automatic check_word(string name, cpu_types_pkg::word_t exp, cpu_types_pkg::word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_reg(string name, cpu_types_pkg::regbits_t exp,
			cpu_types_pkg::regbits_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s dest expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic build_table();
		cpu_types_pkg::id_ex_t id;
		cpu_types_pkg::word_t d;
		for (int op = 0; op < 9; op++) begin
			for (int src = 0; src < 2; src++) begin
				id = make_id(op, src, $urandom, $urandom, $urandom, op[0] ^ src[0], 1, 0, 0, 0, 0);
				add_entry($sformatf("alu_op%0d_src%0d", op, src), id, 0, 0);
			end
		end
		d = $urandom;
		add_entry("store_20", make_id(0, 1, 0, d, 32'h20, 1, 0, 0, 1, 0, 0), 0, 0);
		add_entry("load_20", make_id(0, 1, 0, 0, 32'h20, 1, 1, 1, 0, 0, 1), 0, 0);
		add_entry("load_fresh_40", make_id(0, 1, 0, 0, 32'h40, 1, 1, 1, 0, 0, 1), 0, 0);
		add_entry("flushed_store", make_id(0, 1, 0, $urandom, 32'h44, 1, 1, 0, 1, 0, 0), 0, 1);
		add_entry("load_44", make_id(0, 1, 0, 0, 32'h44, 1, 1, 1, 0, 0, 1), 0, 0);
		id = make_id(0, 1, 0, $urandom, 32'h48, 1, 0, 0, 1, 0, 0);
		for (int i = 0; i < 3; i++) begin
			add_entry($sformatf("stall_%0d", i), id, 1, 0);
		end
		add_entry("store_48", id, 0, 0);
		add_entry("load_48", make_id(0, 1, 0, 0, 32'h48, 1, 1, 1, 0, 0, 1), 0, 0);
		add_entry("nop", '0, 0, 0);
		add_entry("halt", make_id(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0), 0, 0);
		for (int i = 0; i < 5; i++) begin
			id = make_id(0, 0, $urandom, $urandom, 0, 0, 1, 0, 0, 0, 0);
			add_entry($sformatf("after_halt_%0d", i), id, 0, 0);
		end
	endtask

	initial begin
		void'($urandom(62613));
		for (int i = 0; i < cpu_types_pkg::DMEM_WORDS; i++) begin
			m_mem[i] = '0;
		end
		nRST = 1'b0;
		id_ex = '0;
		stall = 1'b0;
		flush = 1'b0;
		build_table();
		built = 1'b1;
		repeat (10) @(posedge CLK);
		#2;
		nRST = 1'b1;
		check_bit("reset_wen", 1'b0, wb.wen);
		check_bit("reset_halt", 1'b0, wb.halt);
		check_bit("reset_halted", 1'b0, halted);
		for (int k = 0; k < id_q.size(); k++) begin
			id_ex = id_q[k];
			stall = stall_q[k];
			flush = flush_q[k];
			@(posedge CLK);
			#2;
			check_word({name_q[k], " wdat"}, exp_q[k].wdat, wb.wdat);
			check_word({name_q[k], " imemaddr"}, exp_q[k].imemaddr, wb.imemaddr);
			check_reg(name_q[k], exp_q[k].dest, wb.dest);
			check_bit({name_q[k], " wen"}, exp_q[k].wen, wb.wen);
			check_bit({name_q[k], " halt"}, exp_q[k].halt, wb.halt);
			check_bit({name_q[k], " halted"}, exp_halted_q[k], halted);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (built);
		#((id_q.size() + 20) * 20);
		$display("timeout: the test table did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* list.f */
verilog/cpu_types_pkg.sv
verilog/execute_stage.sv
verilog/ex_mem_reg.sv
verilog/mem_stage.sv
verilog/mem_wb_reg.sv
verilog/pipe_control.sv
verilog/cpu_back_end.sv
dv/cpu_back_end_checker.sv
dv/cpu_back_end_tb.sv

/* verilog/cpu_back_end.sv */
module cpu_back_end (
	input  logic                   CLK,
	input  logic                   nRST,
	input  cpu_types_pkg::id_ex_t  id_ex,
	input  logic                   stall,
	input  logic                   flush,
	output cpu_types_pkg::mem_wb_t wb,
	output logic                   halted
);

	cpu_types_pkg::ex_mem_t ex_next;
	cpu_types_pkg::ex_mem_t ex_mem;
	cpu_types_pkg::mem_wb_t wb_next;
	logic advance;
	logic ex_mem_flush;
	logic mem_write;

	execute_stage execute_stage_i (
		.id_ex   (id_ex),
		.ex_next (ex_next)
	);

	ex_mem_reg ex_mem_reg_i (
		.CLK     (CLK),
		.nRST    (nRST),
		.ex_next (ex_next),
		.advance (advance),
		.flush   (ex_mem_flush),
		.ex_mem  (ex_mem)
	);

	mem_stage mem_stage_i (
		.CLK       (CLK),
		.nRST      (nRST),
		.ex_mem    (ex_mem),
		.mem_write (mem_write),
		.wb_next   (wb_next)
	);

	mem_wb_reg mem_wb_reg_i (
		.CLK     (CLK),
		.nRST    (nRST),
		.wb_next (wb_next),
		.advance (advance),
		.wb      (wb)
	);

	// steers both registers and the ram write
	pipe_control pipe_control_i (
		.CLK          (CLK),
		.nRST         (nRST),
		.stall        (stall),
		.flush        (flush),
		.wb_halt      (wb.halt),
		.ex_dwen      (ex_mem.dwen),
		.advance      (advance),
		.ex_mem_flush (ex_mem_flush),
		.mem_write    (mem_write),
		.halted       (halted)
	);

endmodule

/* verilog/cpu_types_pkg.sv */
package cpu_types_pkg;

	// basic widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regbits_t;
	typedef logic [3:0]  aluop_t;

	// alu operation codes, shifts use operand b bits 4:0
	localparam aluop_t ALU_ADD = 4'd0;
	localparam aluop_t ALU_SUB = 4'd1;
	localparam aluop_t ALU_AND = 4'd2;
	localparam aluop_t ALU_OR  = 4'd3;
	localparam aluop_t ALU_XOR = 4'd4;
	localparam aluop_t ALU_NOR = 4'd5;
	localparam aluop_t ALU_SLT = 4'd6;
	localparam aluop_t ALU_SLL = 4'd7;
	localparam aluop_t ALU_SRL = 4'd8;

	// destination register select
	typedef logic reg_dest_t;
	localparam reg_dest_t SEL_RD = 1'b0;
	localparam reg_dest_t SEL_RT = 1'b1;

	// write-back data select
	typedef logic mem_to_reg_t;
	localparam mem_to_reg_t SEL_RESULT = 1'b0;
	localparam mem_to_reg_t SEL_DMEM   = 1'b1;

	// data ram size, word addressed from result bits 7:2
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	typedef enum logic {
		PIPE_RUN,
		PIPE_HALTED
	} pipe_state_t;

	// decoded bundle out of the id/ex register
	typedef struct packed {
		word_t       imemaddr;
		aluop_t      alu_op;
		logic        alu_src;
		word_t       rdat1;
		word_t       rdat2;
		word_t       imm_ext;
		regbits_t    rt;
		regbits_t    rd;
		reg_dest_t   reg_dest;
		logic        wen;
		logic        dren;
		logic        dwen;
		logic        halt;
		mem_to_reg_t mem_to_reg;
	} id_ex_t;

	typedef struct packed {
		word_t       imemaddr;
		word_t       result;
		word_t       store_data;
		regbits_t    dest;
		logic        wen;
		logic        dren;
		logic        dwen;
		logic        halt;
		mem_to_reg_t mem_to_reg;
	} ex_mem_t;

	// write-back bundle toward the register file
	typedef struct packed {
		word_t    imemaddr;
		word_t    wdat;
		regbits_t dest;
		logic     wen;
		logic     halt;
	} mem_wb_t;

endpackage

/* verilog/ex_mem_reg.sv */
module ex_mem_reg (
	input  logic                   CLK,
	input  logic                   nRST,
	input  cpu_types_pkg::ex_mem_t ex_next,
	input  logic                   advance,
	input  logic                   flush,
	output cpu_types_pkg::ex_mem_t ex_mem
);

	cpu_types_pkg::ex_mem_t ex_mem_reg_q;
	cpu_types_pkg::ex_mem_t ex_mem_nxt;

	assign ex_mem = ex_mem_reg_q;

	// flush wins over advance, even during a stall
	always_comb begin
		ex_mem_nxt = ex_mem_reg_q;
		if (flush) begin
			ex_mem_nxt = '0;
		end else if (advance) begin
			ex_mem_nxt = ex_next;
		end
	end

	// reset value is a bubble
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ex_mem_reg_q <= '0;
		end else begin
			ex_mem_reg_q <= ex_mem_nxt;
		end
	end

endmodule

/* verilog/execute_stage.sv */
module execute_stage (
	input  cpu_types_pkg::id_ex_t  id_ex,
	output cpu_types_pkg::ex_mem_t ex_next
);

	cpu_types_pkg::word_t    op_b;
	cpu_types_pkg::word_t    result;
	cpu_types_pkg::regbits_t dest;

	// operand b is the register or the extended immediate
	assign op_b = id_ex.alu_src ? id_ex.imm_ext : id_ex.rdat2;

	always_comb begin
		case (id_ex.alu_op)
			cpu_types_pkg::ALU_ADD: begin
				result = id_ex.rdat1 + op_b;
			end
			cpu_types_pkg::ALU_SUB: begin
				result = id_ex.rdat1 - op_b;
			end
			cpu_types_pkg::ALU_AND: begin
				result = id_ex.rdat1 & op_b;
			end
			cpu_types_pkg::ALU_OR: begin
				result = id_ex.rdat1 | op_b;
			end
			cpu_types_pkg::ALU_XOR: begin
				result = id_ex.rdat1 ^ op_b;
			end
			cpu_types_pkg::ALU_NOR: begin
				result = ~(id_ex.rdat1 | op_b);
			end
			cpu_types_pkg::ALU_SLT: begin
				// signed compare
				result = {31'd0, $signed(id_ex.rdat1) < $signed(op_b)};
			end
			cpu_types_pkg::ALU_SLL: begin
				result = id_ex.rdat1 << op_b[4:0];
			end
			cpu_types_pkg::ALU_SRL: begin
				result = id_ex.rdat1 >> op_b[4:0];
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// rt for immediate forms, rd for r-type
	always_comb begin
		case (id_ex.reg_dest)
			cpu_types_pkg::SEL_RT: dest = id_ex.rt;
			cpu_types_pkg::SEL_RD: dest = id_ex.rd;
			default:               dest = id_ex.rd;
		endcase
	end

	always_comb begin
		ex_next.imemaddr   = id_ex.imemaddr;
		ex_next.result     = result;
		ex_next.store_data = id_ex.rdat2;
		ex_next.dest       = dest;
		ex_next.wen        = id_ex.wen;
		ex_next.dren       = id_ex.dren;
		ex_next.dwen       = id_ex.dwen;
		ex_next.halt       = id_ex.halt;
		ex_next.mem_to_reg = id_ex.mem_to_reg;
	end

endmodule

/* verilog/mem_stage.sv */
module mem_stage (
	input  logic                   CLK,
	input  logic                   nRST,
	input  cpu_types_pkg::ex_mem_t ex_mem,
	input  logic                   mem_write,
	output cpu_types_pkg::mem_wb_t wb_next
);

	cpu_types_pkg::word_t dmem [cpu_types_pkg::DMEM_WORDS];
	logic [cpu_types_pkg::DMEM_AW-1:0] word_addr;
	cpu_types_pkg::word_t rd_word;

	// word address, byte offset dropped
	assign word_addr = ex_mem.result[cpu_types_pkg::DMEM_AW+1:2];

	// asynchronous read
	assign rd_word = dmem[word_addr];

	// write gated by pipe_control
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < cpu_types_pkg::DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (mem_write) begin
			dmem[word_addr] <= ex_mem.store_data;
		end
	end

	always_comb begin
		wb_next.imemaddr = ex_mem.imemaddr;
		wb_next.dest     = ex_mem.dest;
		wb_next.wen      = ex_mem.wen;
		wb_next.halt     = ex_mem.halt;
		case (ex_mem.mem_to_reg)
			cpu_types_pkg::SEL_DMEM:   wb_next.wdat = rd_word;
			cpu_types_pkg::SEL_RESULT: wb_next.wdat = ex_mem.result;
			default:                   wb_next.wdat = ex_mem.result;
		endcase
	end

endmodule

/* verilog/mem_wb_reg.sv */
module mem_wb_reg (
	input  logic                   CLK,
	input  logic                   nRST,
	input  cpu_types_pkg::mem_wb_t wb_next,
	input  logic                   advance,
	output cpu_types_pkg::mem_wb_t wb
);

	cpu_types_pkg::mem_wb_t wb_reg_q;
	cpu_types_pkg::mem_wb_t wb_nxt;

	assign wb = wb_reg_q;

	// no flush here, only hold or load
	always_comb begin
		wb_nxt = wb_reg_q;
		if (advance) begin
			wb_nxt = wb_next;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_reg_q <= '0;
		end else begin
			wb_reg_q <= wb_nxt;
		end
	end

endmodule

/* verilog/pipe_control.sv */
module pipe_control (
	input  logic CLK,
	input  logic nRST,
	input  logic stall,
	input  logic flush,
	input  logic wb_halt,
	input  logic ex_dwen,
	output logic advance,
	output logic ex_mem_flush,
	output logic mem_write,
	output logic halted
);

	cpu_types_pkg::pipe_state_t state;
	cpu_types_pkg::pipe_state_t state_nxt;

	// halted is sticky until reset
	always_comb begin
		state_nxt = state;
		case (state)
			cpu_types_pkg::PIPE_RUN: begin
				if (wb_halt) begin
					state_nxt = cpu_types_pkg::PIPE_HALTED;
				end
			end
			cpu_types_pkg::PIPE_HALTED: begin
				state_nxt = cpu_types_pkg::PIPE_HALTED;
			end
			default: begin
				state_nxt = cpu_types_pkg::PIPE_RUN;
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= cpu_types_pkg::PIPE_RUN;
		end else begin
			state <= state_nxt;
		end
	end

	assign advance      = (state == cpu_types_pkg::PIPE_RUN) && !stall;
	assign ex_mem_flush = flush;
	// store only commits on an edge that moves it on
	assign mem_write    = ex_dwen && advance;
	assign halted       = (state == cpu_types_pkg::PIPE_HALTED);

endmodule
